// File: common/rvPkg.sv
package rvPkg;

    localparam int XLEN = 32;

    // base opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    typedef enum logic [3:0] {
        init, fetch, decode,
        execR, execLoad, execImm, execStore,
        execBranch, execJalr, execJal, execAuipc,
        writeBackReg, writeBackMem
    } ctrlState_t;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01,
        aluFunct  = 2'b10
    } aluOp_t;

    // operand B and writeback source
    typedef enum logic [1:0] {
        selReg  = 2'b00,
        selMem  = 2'b01,
        selImm  = 2'b10,
        selLink = 2'b11
    } opSel_t;

    typedef struct packed {
        logic   pcWe;
        logic   irWe;
        logic   rfWe;
        logic   memWe;
        aluOp_t aluOp;
        opSel_t opSel;
        logic   selJal;
        logic   selJalr;
    } ctrlBus_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } memReq_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        rFmt_t           rFmt;
        iFmt_t           iFmt;
    } instrWord_t;

endpackage

// File: compile.f
common/rvPkg.sv
control/controlUnit.sv
datapath/regFile.sv
datapath/aluUnit.sv
datapath/immGen.sv
datapath/dataPath.sv
design/cpuTop.sv
verif/cpuChk_chk.sv
verif/cpuTb.sv

// File: control/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import rvPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] opcode,
    input  logic       branchTaken,
    output ctrlBus_t   ctrl,
    output ctrlState_t state
);

    ctrlState_t nextState;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= init;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            init:   nextState = fetch;
            fetch:  nextState = decode;
            decode: begin
                case (opcode)
                    opR:      nextState = execR;
                    opLoad:   nextState = execLoad;
                    opImm:    nextState = execImm;
                    opStore:  nextState = execStore;
                    opBranch: nextState = execBranch;
                    opJalr:   nextState = execJalr;
                    opJal:    nextState = execJal;
                    opAuipc:  nextState = execAuipc;
                    // unknown opcode acts as a no-op
                    default:  nextState = fetch;
                endcase
            end
            execStore:    nextState = writeBackMem;
            execBranch:   nextState = fetch;
            execR, execLoad, execImm, execJalr, execJal, execAuipc: begin
                nextState = writeBackReg;
            end
            writeBackReg: nextState = fetch;
            writeBackMem: nextState = fetch;
            default:      nextState = init;
        endcase
    end

    // control bundle straight from the current state
    always_comb begin
        ctrl         = '0;
        ctrl.aluOp   = aluAdd;
        ctrl.opSel   = selReg;
        case (state)
            fetch: begin
                ctrl.pcWe = 1'b1;
                ctrl.irWe = 1'b1;
            end
            execR: begin
                ctrl.aluOp = aluFunct;
                ctrl.opSel = selReg;
            end
            execLoad: begin
                ctrl.opSel = selMem;
            end
            execImm: begin
                ctrl.opSel = selImm;
            end
            execStore: begin
                ctrl.opSel = selMem;
            end
            execBranch: begin
                ctrl.aluOp = aluBranch;
                ctrl.opSel = selReg;
                ctrl.pcWe  = branchTaken;
            end
            execJalr: begin
                ctrl.opSel   = selLink;
                ctrl.selJalr = 1'b1;
                ctrl.pcWe    = 1'b1;
            end
            execJal: begin
                ctrl.opSel  = selLink;
                ctrl.selJal = 1'b1;
                ctrl.pcWe   = 1'b1;
            end
            execAuipc: begin
                ctrl.opSel = selLink;
            end
            writeBackReg: begin
                ctrl.rfWe = 1'b1;
                // loads take memory data, everything else the result register
                if (opcode == opLoad) begin
                    ctrl.opSel = selMem;
                end
            end
            writeBackMem: begin
                ctrl.memWe = 1'b1;
            end
            default: begin
                ctrl.pcWe = 1'b0;
            end
        endcase
    end

endmodule

// File: datapath/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import rvPkg::*; (
    input  aluOp_t          aluOp,
    input  logic [2:0]      funct3,
    input  logic            funct7b5,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            branchTaken
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lessThan;
    logic            cond;

    assign sum      = a + b;
    assign diff     = a - b;
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        result = sum;
        if (aluOp == aluFunct) begin
            case (funct3)
                3'b000:  result = funct7b5 ? diff : sum;
                3'b010:  result = {{(XLEN-1){1'b0}}, lessThan};
                3'b100:  result = a ^ b;
                3'b110:  result = a | b;
                3'b111:  result = a & b;
                default: result = sum;
            endcase
        end
    end

    // branch condition uses signed compares only
    always_comb begin
        case (funct3)
            3'b000:  cond = (diff == '0);
            3'b001:  cond = (diff != '0);
            3'b100:  cond = lessThan;
            3'b101:  cond = !lessThan;
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken = (aluOp == aluBranch) && cond;

endmodule

// File: datapath/dataPath.sv
`timescale 1ns/1ps

module dataPath import rvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  ctrlBus_t        ctrl,
    input  logic [XLEN-1:0] memRdata,
    output memReq_t         memReq,
    output logic [6:0]      opcode,
    output logic            branchTaken
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] oldPc;
    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] linkVal;
    instrWord_t      ir;
    logic [XLEN-1:0] resultReg;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] operandB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] wbData;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pcWe) begin
            pc <= pcNext;
        end
    end

    // instruction and its address are captured together in fetch
    always_ff @(posedge clk) begin
        if (ctrl.irWe) begin
            ir    <= memRdata;
            oldPc <= pc;
        end
    end

    // execute result held for the writeback cycle
    always_ff @(posedge clk) begin
        resultReg <= (ctrl.opSel == selLink) ? linkVal : aluResult;
    end

    assign pcTarget = oldPc + imm;
    assign linkVal  = (ctrl.selJal || ctrl.selJalr) ? oldPc + XLEN'(4) : pcTarget;

    always_comb begin
        if (ctrl.irWe) begin
            pcNext = pc + XLEN'(4);
        end else if (ctrl.selJalr) begin
            pcNext = {aluResult[XLEN-1:1], 1'b0};
        end else begin
            pcNext = pcTarget;
        end
    end

    assign operandB = (ctrl.opSel == selReg) ? rdata2 : imm;
    assign wbData   = (ctrl.opSel == selMem) ? memRdata : resultReg;

    regFile rfInst (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ir.iFmt.rs1),
        .rs2    (ir.rFmt.rs2),
        .rd     (ir.iFmt.rd),
        .we     (ctrl.rfWe),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    aluUnit aluInst (
        .aluOp       (ctrl.aluOp),
        .funct3      (ir.iFmt.funct3),
        .funct7b5    (ir.rFmt.funct7[5]),
        .a           (rdata1),
        .b           (operandB),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    immGen immInst (
        .instr (ir),
        .imm   (imm)
    );

    // pc during fetch, load/store address otherwise
    assign memReq.addr  = ctrl.irWe ? pc : resultReg;
    assign memReq.wdata = rdata2;
    assign memReq.we    = ctrl.memWe;

    assign opcode = ir.rFmt.opcode;

endmodule

// File: datapath/immGen.sv
`timescale 1ns/1ps

module immGen import rvPkg::*; (
    input  instrWord_t      instr,
    output logic [XLEN-1:0] imm
);

    logic [XLEN-1:0] raw;

    assign raw = instr.raw;

    always_comb begin
        case (instr.rFmt.opcode)
            opLoad, opImm, opJalr: begin
                imm = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
            end
            opStore: begin
                imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            end
            // B and J immediates are in halfword units
            opBranch: begin
                imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            opJal: begin
                imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            opAuipc: begin
                imm = {raw[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: datapath/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 never written so it reads zero
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import rvPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] memRdata,
    output memReq_t         memReq
);

    ctrlBus_t   ctrl;
    logic [6:0] opcode;
    logic       branchTaken;

    controlUnit ctrlInst (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .branchTaken (branchTaken),
        .ctrl        (ctrl),
        .state       ()
    );

    dataPath dpInst (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .memRdata    (memRdata),
        .memReq      (memReq),
        .opcode      (opcode),
        .branchTaken (branchTaken)
    );

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module cpuTb -o cpuSim \
    && ./obj_dir/cpuSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^Test OK$' sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/cpuChk_chk.sv
`timescale 1ns/1ps

module cpuChk import rvPkg::*; (
    input logic       clk,
    input logic       reset,
    input ctrlBus_t   ctrl,
    input ctrlState_t state
);

    int errCount = 0;

    // a store never shares a cycle with a register write
    noStoreAndWrite: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.memWe && ctrl.rfWe))
        else begin
            $error("memWe and rfWe high in the same cycle");
            errCount = errCount + 1;
        end

    irWeOnlyInFetch: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWe |-> state == fetch)
        else begin
            $error("irWe high outside fetch");
            errCount = errCount + 1;
        end

    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> (state == init && !ctrl.pcWe && !ctrl.irWe
                          && !ctrl.rfWe && !ctrl.memWe))
        else begin
            $error("enables not all low in the cycle after reset");
            errCount = errCount + 1;
        end

endmodule

// File: verif/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import rvPkg::*; ();

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } storeExp_t;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] memRdata;
    memReq_t         memReq;

    // 1K words byte addressed through addr[11:2]
    logic [XLEN-1:0] mem [1024];
    storeExp_t       expQ [$];

    cpuTop UUT (
        .clk      (clk),
        .reset    (reset),
        .memRdata (memRdata),
        .memReq   (memReq)
    );

    bind controlUnit cpuChk chkInst (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .state (state)
    );

    assign memRdata = mem[memReq.addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (memReq.we) begin
            mem[memReq.addr[11:2]] <= memReq.wdata;
        end
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // fetches stay word aligned and the bound checker stays quiet
    always @(negedge clk) begin
        if (!reset && UUT.ctrlInst.ctrl.irWe) begin
            assert (memReq.addr[1:0] == 2'b00) else stopWithError($sformatf(
                "MISMATCH at %0t: fetch memReq.addr[1:0] got %b expected %b",
                $time, memReq.addr[1:0], 2'b00));
        end
        if (UUT.ctrlInst.chkInst.errCount != 0) begin
            stopWithError("bound control unit assertions reported errors");
        end
    end

    initial begin
        int              fd;
        int              n;
        int              cycles;
        string           line;
        logic [7:0]      tag;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        storeExp_t       want;

        reset <= 1'b1;
        for (int i = 0; i < 1024; i++) begin
            mem[i] <= '0;
        end

        fd = $fopen("verif/cpuTrace.txt", "r");
        if (fd == 0) begin
            stopWithError("cannot open the trace file verif/cpuTrace.txt");
        end
        // P lines preload memory, S lines queue the expected stores
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1) begin
                tag = line.getc(0);
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                if (tag == "P" && n == 2) begin
                    mem[a[11:2]] <= d;
                end else if (tag == "S" && n == 2) begin
                    want.addr = a;
                    want.data = d;
                    expQ.push_back(want);
                end
            end
        end
        $fclose(fd);
        if (expQ.size() == 0) begin
            stopWithError("the trace file holds no expected stores");
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // one init cycle, then the first fetch from address 0
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) begin
                stopWithError("no instruction fetch started after reset");
            end
        end while (!UUT.ctrlInst.ctrl.irWe);
        assert (cycles == 2) else stopWithError($sformatf(
            "MISMATCH at %0t: first fetch cycle got %0d expected %0d", $time, cycles, 2));
        assert (memReq.addr == '0) else stopWithError($sformatf(
            "MISMATCH at %0t: memReq.addr got %h expected %h", $time, memReq.addr, 32'h0));

        foreach (expQ[k]) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > 200) begin
                    stopWithError($sformatf(
                        "timeout: expected store %0d to address %h never happened",
                        k, expQ[k].addr));
                end
            end while (!memReq.we);
            assert (memReq.addr == expQ[k].addr) else stopWithError($sformatf(
                "MISMATCH at %0t: memReq.addr got %h expected %h",
                $time, memReq.addr, expQ[k].addr));
            assert (memReq.wdata == expQ[k].data) else stopWithError($sformatf(
                "MISMATCH at %0t: memReq.wdata got %h expected %h",
                $time, memReq.wdata, expQ[k].data));
        end

        // program ends in a jump to itself, so no more stores
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            assert (!memReq.we) else stopWithError($sformatf(
                "unexpected extra store to address %h", memReq.addr));
        end

        if (UUT.ctrlInst.chkInst.errCount != 0) begin
            stopWithError("bound control unit assertions reported errors");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: verif/cpuTrace.txt
# P <byte address> <instruction word>   preloads memory
# S <byte address> <store data>         next expected store, in program order
P 000 12300093
P 004 FFA00113
P 008 10202023
P 00C 002081B3
P 010 10302223
P 014 40208233
P 018 10402423
P 01C 0020F2B3
P 020 10502623
P 024 0020E2B3
P 028 10502823
P 02C 0020C2B3
P 030 10502A23
P 034 001122B3
P 038 10502C23
P 03C 10802483
P 040 10902E23
P 044 00208463
P 048 14102023
P 04C 00108463
P 050 14102223
P 054 00109463
P 058 14102423
P 05C 00209463
P 060 14102623
P 064 0020C463
P 068 14102823
P 06C 00114463
P 070 14102A23
P 074 00115463
P 078 14102C23
P 07C 0020D463
P 080 14102E23
P 084 0080036F
P 088 1E102823
P 08C 16602023
P 090 00001417
P 094 16802223
P 098 019303E7
P 09C 1E102A23
P 0A0 16702423
P 0A4 FFFFFFFF
P 0A8 16102623
P 0AC 0000006F
S 100 FFFFFFFA
S 104 0000011D
S 108 00000129
S 10C 00000122
S 110 FFFFFFFB
S 114 FFFFFED9
S 118 00000001
S 11C 00000129
S 140 00000123
S 148 00000123
S 150 00000123
S 158 00000123
S 160 00000088
S 164 00001090
S 168 0000009C
S 16C 00000123
